// ==== lcdPkg.sv ====
`default_nettype none

package lcdPkg;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // isData low selects a command cycle
    typedef struct packed {
        logic        isData;
        logic [15:0] value;
    } busWord_t;

    typedef struct packed {
        logic [15:0] data;
        logic        command;
        logic        select;
        logic        write;
    } lcdPins_t;

    typedef enum logic [1:0] {
        waitShort,
        waitMid,
        waitLong
    } waitClass_t;

    localparam logic [15:0] cmdMemoryWrite = 16'h002C;

    localparam rgb565_t colourRed   = 16'hF800;
    localparam rgb565_t colourGreen = 16'h07E0;
    localparam rgb565_t colourBlack = 16'h0000;

    localparam int unsigned initWordCount = 68;
    localparam int unsigned barWidth      = 4;  // green bar columns

endpackage

`default_nettype wire

// ==== lcdInitRom.sv ====
`default_nettype none

module lcdInitRom import lcdPkg::*; (
    input  logic [6:0] step,
    output logic       isWait,
    output waitClass_t waitKind,
    output busWord_t   word,
    output logic       last
);

    // 68 words plus four waits
    localparam logic [6:0] lastStep = 7'(initWordCount + 3);

    function automatic busWord_t cmd(input logic [7:0] code);
        return busWord_t'{1'b0, {8'h00, code}};
    endfunction

    function automatic busWord_t dat(input logic [7:0] value);
        return busWord_t'{1'b1, {8'h00, value}};
    endfunction

    always_comb begin
        isWait   = 1'b0;
        waitKind = waitShort;
        last     = 1'b0;
        word     = dat(8'h00);  // most parameter bytes are zero
        case (step)
            7'd0:  word = cmd(8'h01);  // software reset
            7'd2: begin
                isWait   = 1'b1;
                waitKind = waitMid;
            end
            7'd3:  word = cmd(8'h28);  // display off
            7'd5:  word = cmd(8'hC0);
            7'd8:  word = cmd(8'hC1);
            7'd11: word = cmd(8'hC2);
            7'd13: word = cmd(8'hC5);
            7'd16: word = cmd(8'hB6);
            7'd20: word = cmd(8'hE0);  // positive gamma
            7'd36: word = cmd(8'hE1);  // negative gamma
            7'd52: word = cmd(8'h20);
            7'd53: word = cmd(8'h36);
            7'd55: word = cmd(8'h3A);  // 16 bit pixels
            7'd57: word = cmd(8'h11);  // sleep out
            7'd58: begin
                isWait   = 1'b1;
                waitKind = waitLong;
            end
            7'd59: word = cmd(8'h29);  // display on
            7'd60: begin
                isWait   = 1'b1;
                waitKind = waitShort;
            end
            7'd61: word = cmd(8'h2A);
            7'd66: word = cmd(8'h2B);
            lastStep: begin
                isWait   = 1'b1;
                waitKind = waitLong;
                last     = 1'b1;
            end
            7'd6, 7'd7:   word = dat(8'h0D);
            7'd9, 7'd27:  word = dat(8'h43);
            7'd15:        word = dat(8'h48);
            7'd18:        word = dat(8'h22);
            7'd19:        word = dat(8'h3B);
            7'd21, 7'd25, 7'd30, 7'd33, 7'd37, 7'd41, 7'd42: begin
                word = dat(8'h0F);
            end
            7'd22:        word = dat(8'h24);
            7'd23:        word = dat(8'h1C);
            7'd24, 7'd54: word = dat(8'h0A);
            7'd26:        word = dat(8'h08);
            7'd28:        word = dat(8'h88);
            7'd29:        word = dat(8'h32);
            7'd31, 7'd47: word = dat(8'h10);
            7'd32:        word = dat(8'h06);
            7'd34, 7'd46: word = dat(8'h07);
            7'd38:        word = dat(8'h38);
            7'd39:        word = dat(8'h30);
            7'd40:        word = dat(8'h09);
            7'd43:        word = dat(8'h4E);
            7'd44:        word = dat(8'h77);
            7'd45:        word = dat(8'h3C);
            7'd48:        word = dat(8'h05);
            7'd49:        word = dat(8'h23);
            7'd50:        word = dat(8'h1B);
            7'd56:        word = dat(8'h55);
            7'd64, 7'd69: word = dat(8'h01);  // end address high byte
            7'd65:        word = dat(8'h3F);
            7'd70:        word = dat(8'hDF);
            default:      word = dat(8'h00);
        endcase
    end

endmodule

`default_nettype wire

// ==== lcdInitSeq.sv ====
`default_nettype none

module lcdInitSeq import lcdPkg::*; #(
    parameter int unsigned startupDelay      = 1400000,
    parameter int unsigned resetLowDelay     = 297000,
    parameter int unsigned resetRecoverDelay = 3500000,
    parameter int unsigned shortDelay        = 700000,
    parameter int unsigned midDelay          = 1400000,
    parameter int unsigned longDelay         = 4100000
) (
    input  logic     clock,
    input  logic     arstN,
    output busWord_t initWord,
    output logic     initValid,
    input  logic     initReady,
    output logic     lcdReset,
    output logic     initDone
);

    typedef enum logic [2:0] {
        phStartup,
        phResetLow,
        phRecover,
        phTable,
        phDone
    } phase_t;

    phase_t      phase;
    logic [31:0] delayCount;
    logic [31:0] delayLimit;
    logic        delayDone;
    logic        counting;
    logic [6:0]  step;
    logic        isWait;
    logic        last;
    waitClass_t  waitKind;

    lcdInitRom u_initRom (
        .step     (step),
        .isWait   (isWait),
        .waitKind (waitKind),
        .word     (initWord),
        .last     (last)
    );

    always_comb begin
        case (phase)
            phResetLow: delayLimit = resetLowDelay;
            phRecover:  delayLimit = resetRecoverDelay;
            phTable: begin
                case (waitKind)
                    waitShort: delayLimit = shortDelay;
                    waitMid:   delayLimit = midDelay;
                    default:   delayLimit = longDelay;
                endcase
            end
            default:    delayLimit = startupDelay;
        endcase
    end

    assign counting  = (phase != phDone) && (phase != phTable || isWait);
    assign delayDone = (delayCount + 32'd1 >= delayLimit);
    assign initValid = (phase == phTable) && !isWait;
    assign lcdReset  = (phase != phResetLow);
    assign initDone  = (phase == phDone);

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            phase      <= phStartup;
            delayCount <= '0;
            step       <= '0;
        end else begin
            if (counting) begin
                delayCount <= delayDone ? '0 : delayCount + 32'd1;
            end
            case (phase)
                phStartup: begin
                    if (delayDone) begin
                        phase <= phResetLow;
                    end
                end
                phResetLow: begin
                    if (delayDone) begin
                        phase <= phRecover;
                    end
                end
                phRecover: begin
                    if (delayDone) begin
                        phase <= phTable;
                    end
                end
                phTable: begin
                    if (isWait && delayDone) begin
                        if (last) begin
                            phase <= phDone;
                        end else begin
                            step <= step + 7'd1;
                        end
                    end else if (!isWait && initReady) begin
                        step <= step + 7'd1;  // word accepted
                    end
                end
                default: phase <= phDone;
            endcase
        end
    end

    // no word is offered before a reset phase or table wait has run out
    assert property (@(posedge clock) disable iff (!arstN)
        counting && !delayDone |=> !initValid);

endmodule

`default_nettype wire

// ==== lcdBusWriter.sv ====
`default_nettype none

module lcdBusWriter import lcdPkg::*; (
    input  logic     clock,
    input  logic     arstN,
    input  busWord_t word,
    input  logic     wordValid,
    output logic     wordReady,
    output lcdPins_t pins
);

    logic       busy;
    logic [2:0] cycle;  // clocks since the word was taken

    assign wordReady = !busy;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            busy  <= 1'b0;
            cycle <= '0;
            pins  <= '{data: '0, command: 1'b0, select: 1'b1, write: 1'b1};
        end else if (!busy) begin
            if (wordValid) begin
                busy         <= 1'b1;
                cycle        <= '0;
                pins.data    <= word.value;
                pins.command <= word.isData;
                pins.select  <= 1'b0;
            end
        end else begin
            cycle <= cycle + 3'd1;
            if (cycle == 3'd1) begin
                pins.write <= 1'b0;  // strobe low for three clocks
            end
            if (cycle == 3'd4) begin
                pins.write <= 1'b1;  // panel latches on this edge
            end
            if (cycle == 3'd6) begin
                pins.select <= 1'b1;
                busy        <= 1'b0;
            end
        end
    end

    // strobe only inside a select window that opened earlier
    assert property (@(posedge clock) disable iff (!arstN)
        !pins.write |-> !pins.select && $past(!pins.select));

endmodule

`default_nettype wire

// ==== lcdPixelStream.sv ====
`default_nettype none

module lcdPixelStream import lcdPkg::*; #(
    parameter int unsigned frameWidth  = 480,
    parameter int unsigned frameHeight = 320,
    parameter int unsigned boxLeft     = 210,
    parameter int unsigned boxTop      = 130,
    parameter int unsigned boxSize     = 60
) (
    input  logic                       clock,
    input  logic                       arstN,
    input  logic                       initDone,
    input  busWord_t                   initWord,
    input  logic                       initValid,
    output logic                       initReady,
    output busWord_t                   word,
    output logic                       wordValid,
    input  logic                       wordReady,
    output logic [$clog2(boxSize)-1:0] boxAddrX,
    output logic [$clog2(boxSize)-1:0] boxAddrY,
    input  rgb565_t                    boxColour
);

    localparam int xWidth   = $clog2(frameWidth);
    localparam int yWidth   = $clog2(frameHeight);
    localparam int boxWidth = $clog2(boxSize);

    logic [xWidth-1:0] x;  // next pixel to load
    logic [yWidth-1:0] y;
    logic [xWidth-1:0] relX;
    logic [yWidth-1:0] relY;
    logic              inBox;
    logic              needCmd;
    logic              load;
    rgb565_t           pixelColour;
    busWord_t          streamWord;
    logic              streamValid;

    assign relX     = x - xWidth'(boxLeft);
    assign relY     = y - yWidth'(boxTop);
    assign boxAddrX = relX[boxWidth-1:0];
    assign boxAddrY = relY[boxWidth-1:0];

    assign inBox = (x >= boxLeft) && (x < boxLeft + boxSize)
                && (y >= boxTop) && (y < boxTop + boxSize);
    assign pixelColour = inBox ? boxColour : colourBlack;

    // output register refills when empty or when its word is taken
    assign load = initDone && (!streamValid || wordReady);

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            x           <= '0;
            y           <= '0;
            needCmd     <= 1'b1;
            streamValid <= 1'b0;
        end else if (load) begin
            streamValid <= 1'b1;
            if (needCmd) begin
                needCmd <= 1'b0;
            end else if (y == yWidth'(frameHeight - 1)) begin
                y <= '0;
                if (x == xWidth'(frameWidth - 1)) begin
                    x       <= '0;
                    needCmd <= 1'b1;  // next frame opens with 0x2C
                end else begin
                    x <= x + 1'b1;
                end
            end else begin
                y <= y + 1'b1;  // column-major scan
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            streamWord <= needCmd ? busWord_t'{1'b0, cmdMemoryWrite}
                                  : busWord_t'{1'b1, pixelColour};
        end
    end

    // init words pass straight through until the table is done
    assign word      = initDone ? streamWord : initWord;
    assign wordValid = initDone ? streamValid : initValid;
    assign initReady = !initDone && wordReady;

    assert property (@(posedge clock) disable iff (!arstN)
        x < frameWidth && y < frameHeight);

endmodule

`default_nettype wire

// ==== boxPainter.sv ====
`default_nettype none

module boxPainter import lcdPkg::*; #(
    parameter int unsigned boxSize    = 60,
    parameter int unsigned animPeriod = 20000
) (
    input  logic                       clock,
    input  logic                       arstN,
    input  logic                       enable,
    input  logic [$clog2(boxSize)-1:0] boxAddrX,
    input  logic [$clog2(boxSize)-1:0] boxAddrY,
    output rgb565_t                    boxColour
);

    localparam int          addrWidth = $clog2(boxSize);
    localparam int          cellCount = boxSize * boxSize;
    localparam int          cellWidth = $clog2(cellCount);
    localparam int unsigned lastPhase = boxSize - barWidth;

    rgb565_t              mem [cellCount];
    logic [addrWidth-1:0] sweepX;
    logic [addrWidth-1:0] sweepY;
    logic [addrWidth-1:0] phase;  // leftmost bar column
    logic [31:0]          tick;
    logic [cellWidth-1:0] writeIndex;
    logic [cellWidth-1:0] readIndex;
    logic                 onBorder;
    logic                 inBar;
    rgb565_t              paintColour;

    assign writeIndex = cellWidth'(sweepY * boxSize + sweepX);
    assign readIndex  = cellWidth'(boxAddrY * boxSize + boxAddrX);
    assign boxColour  = mem[readIndex];

    assign onBorder = (sweepX == 0) || (sweepX == addrWidth'(boxSize - 1))
                   || (sweepY == 0) || (sweepY == addrWidth'(boxSize - 1));
    assign inBar    = (sweepX >= phase) && (sweepX < phase + barWidth);

    assign paintColour = onBorder ? colourRed : (inBar ? colourGreen : colourBlack);

    always_ff @(posedge clock) begin
        if (enable) begin
            mem[writeIndex] <= paintColour;
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            sweepX <= '0;
            sweepY <= '0;
        end else if (enable) begin
            if (sweepX == addrWidth'(boxSize - 1)) begin
                sweepX <= '0;
                sweepY <= (sweepY == addrWidth'(boxSize - 1)) ? '0 : sweepY + 1'b1;
            end else begin
                sweepX <= sweepX + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            tick  <= '0;
            phase <= '0;
        end else if (enable) begin
            if (tick == animPeriod) begin
                tick  <= '0;
                phase <= (phase >= lastPhase) ? '0 : phase + 1'b1;  // bar steps right
            end else begin
                tick <= tick + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== lcdTop.sv ====
`default_nettype none

module lcdTop import lcdPkg::*; #(
    parameter int unsigned startupDelay      = 1400000,
    parameter int unsigned resetLowDelay     = 297000,
    parameter int unsigned resetRecoverDelay = 3500000,
    parameter int unsigned shortDelay        = 700000,
    parameter int unsigned midDelay          = 1400000,
    parameter int unsigned longDelay         = 4100000,
    parameter int unsigned frameWidth        = 480,
    parameter int unsigned frameHeight       = 320,
    parameter int unsigned boxLeft           = 210,
    parameter int unsigned boxTop            = 130,
    parameter int unsigned boxSize           = 60,
    parameter int unsigned animPeriod        = 20000
) (
    input  logic     clock,
    input  logic     arstN,
    output lcdPins_t pins,
    output logic     lcdReset,
    output logic     ready
);

    busWord_t                   initWord;
    logic                       initValid;
    logic                       initReady;
    busWord_t                   word;
    logic                       wordValid;
    logic                       wordReady;
    logic [$clog2(boxSize)-1:0] boxAddrX;
    logic [$clog2(boxSize)-1:0] boxAddrY;
    rgb565_t                    boxColour;

    lcdInitSeq #(
        .startupDelay      (startupDelay),
        .resetLowDelay     (resetLowDelay),
        .resetRecoverDelay (resetRecoverDelay),
        .shortDelay        (shortDelay),
        .midDelay          (midDelay),
        .longDelay         (longDelay)
    ) u_initSeq (
        .clock     (clock),
        .arstN     (arstN),
        .initWord  (initWord),
        .initValid (initValid),
        .initReady (initReady),
        .lcdReset  (lcdReset),
        .initDone  (ready)
    );

    lcdPixelStream #(
        .frameWidth  (frameWidth),
        .frameHeight (frameHeight),
        .boxLeft     (boxLeft),
        .boxTop      (boxTop),
        .boxSize     (boxSize)
    ) u_pixelStream (
        .clock     (clock),
        .arstN     (arstN),
        .initDone  (ready),
        .initWord  (initWord),
        .initValid (initValid),
        .initReady (initReady),
        .word      (word),
        .wordValid (wordValid),
        .wordReady (wordReady),
        .boxAddrX  (boxAddrX),
        .boxAddrY  (boxAddrY),
        .boxColour (boxColour)
    );

    boxPainter #(
        .boxSize    (boxSize),
        .animPeriod (animPeriod)
    ) u_boxPainter (
        .clock     (clock),
        .arstN     (arstN),
        .enable    (ready),  // paint once the panel is set up
        .boxAddrX  (boxAddrX),
        .boxAddrY  (boxAddrY),
        .boxColour (boxColour)
    );

    lcdBusWriter u_busWriter (
        .clock     (clock),
        .arstN     (arstN),
        .word      (word),
        .wordValid (wordValid),
        .wordReady (wordReady),
        .pins      (pins)
    );

endmodule

`default_nettype wire

// ==== tbClockGen.sv ====
`default_nettype none

module tbClockGen #(
    parameter int period      = 40,
    parameter int resetCycles = 16
) (
    output logic clock,
    output logic arstN
);

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(negedge clock);
        arstN = 1'b1;  // released on a falling edge
    end

endmodule

`default_nettype wire

// ==== lcdTb.sv ====
`default_nettype none

module lcdTb import lcdPkg::*; ();

    localparam int startupDelay      = 20;
    localparam int resetLowDelay     = 10;
    localparam int resetRecoverDelay = 30;
    localparam int shortDelay        = 5;
    localparam int midDelay          = 8;
    localparam int longDelay         = 12;
    localparam int frameWidth        = 24;
    localparam int frameHeight       = 16;
    localparam int boxLeft           = 6;
    localparam int boxTop            = 4;
    localparam int boxSize           = 8;
    localparam int animPeriod        = 3000;

    localparam int frameWords = frameWidth * frameHeight + 1;  // 0x2C plus pixels
    localparam int initWords  = 68;
    localparam int delaySum   = startupDelay + resetLowDelay + resetRecoverDelay
                              + midDelay + 2 * longDelay + shortDelay;
    localparam int cycleLimit = 2 * (delaySum + (initWords + 3 * frameWords) * 8);

    localparam rgb565_t  expRed      = 16'hF800;
    localparam rgb565_t  expGreen    = 16'h07E0;
    localparam rgb565_t  expBlack    = 16'h0000;
    localparam busWord_t memWriteCmd = '{1'b0, 16'h002C};
    localparam logic [16*8-1:0] initCommands = {
        8'h01, 8'h28, 8'hC0, 8'hC1, 8'hC2, 8'hC5, 8'hB6, 8'hE0,
        8'hE1, 8'h20, 8'h36, 8'h3A, 8'h11, 8'h29, 8'h2A, 8'h2B
    };

    logic     clock;
    logic     arstN;
    lcdPins_t pins;
    logic     lcdReset;
    logic     ready;

    busWord_t captured [$];
    int       checkCount  = 0;
    int       errorCount  = 0;
    int       testCount   = 0;
    int       cycleCount  = 0;
    int       fallCount   = 0;
    int       lowWidth    = 0;
    logic     resetWasLow = 1'b0;
    logic     pulseDone   = 1'b0;
    logic     earlyStrobe = 1'b0;
    int       leftmost [3];

    tbClockGen #(.period(40), .resetCycles(16)) u_clockGen (
        .clock (clock),
        .arstN (arstN)
    );

    lcdTop #(
        .startupDelay      (startupDelay),
        .resetLowDelay     (resetLowDelay),
        .resetRecoverDelay (resetRecoverDelay),
        .shortDelay        (shortDelay),
        .midDelay          (midDelay),
        .longDelay         (longDelay),
        .frameWidth        (frameWidth),
        .frameHeight       (frameHeight),
        .boxLeft           (boxLeft),
        .boxTop            (boxTop),
        .boxSize           (boxSize),
        .animPeriod        (animPeriod)
    ) u_lcdTop (
        .clock    (clock),
        .arstN    (arstN),
        .pins     (pins),
        .lcdReset (lcdReset),
        .ready    (ready)
    );

    // panel latches on the rising write edge
    always @(posedge pins.write) begin
        if (arstN) begin
            captured.push_back(busWord_t'{pins.command, pins.data});
        end
    end

    always @(negedge pins.write) begin
        if (arstN && !pulseDone) begin
            earlyStrobe = 1'b1;
        end
    end

    always @(negedge clock) begin
        if (arstN) begin
            if (!lcdReset) begin
                if (!resetWasLow) begin
                    fallCount++;
                end
                lowWidth++;
            end else if (resetWasLow) begin
                pulseDone = 1'b1;
            end
            resetWasLow = !lcdReset;
        end
    end

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the DUT did not produce the expected words in %0d cycles",
                     cycleLimit);
            $display("tests failed");
            $finish;
        end
    end

    task automatic checkWord(input string name, input busWord_t got, input busWord_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic checkColour(input string name, input rgb565_t got, input rgb565_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR at %0t: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testCount++;
        $display("%s: %s", name, (errorCount == errorsBefore) ? "PASS" : "FAIL");
    endtask

    task automatic waitWords(input int count);
        while (captured.size() < count) begin
            @(negedge clock);
        end
    endtask

    task automatic checkIdlePins(input string when);
        checkBit({when, " pins.select"}, pins.select, 1'b1);
        checkBit({when, " pins.write"}, pins.write, 1'b1);
        checkBit({when, " lcdReset"}, lcdReset, 1'b1);
        checkBit({when, " ready"}, ready, 1'b0);
        checkWord({when, " pins.command/data"}, busWord_t'{pins.command, pins.data}, '0);
    endtask

    task automatic testResetState();
        int errorsBefore;
        errorsBefore = errorCount;
        repeat (4) @(negedge clock);
        checkIdlePins("in reset");
        @(posedge arstN);
        @(negedge clock);
        checkIdlePins("after reset");
        reportTest("reset state", errorsBefore);
    endtask

    task automatic testResetPulse();
        int errorsBefore;
        errorsBefore = errorCount;
        while (!pulseDone) begin
            @(negedge clock);
        end
        checkBit("lcdReset fell once", fallCount == 1, 1'b1);
        checkBit("lcdReset low width near 10",
                 lowWidth >= resetLowDelay - 1 && lowWidth <= resetLowDelay + 1, 1'b1);
        checkBit("write strobe before reset pulse ended", earlyStrobe, 1'b0);
        reportTest("reset pulse", errorsBefore);
    endtask

    task automatic testInitWords();
        int       errorsBefore;
        int       cmdIndex;
        int       dataCount;
        int       index2B;
        busWord_t w;
        errorsBefore = errorCount;
        cmdIndex     = 0;
        dataCount    = 0;
        index2B      = 2;
        waitWords(initWords);
        for (int i = 0; i < initWords; i++) begin
            w = captured[i];
            if (w.isData) begin
                dataCount++;
            end else begin
                if (cmdIndex < 16) begin
                    checkWord($sformatf("init word %0d", i), w,
                              busWord_t'{1'b0, {8'h00, initCommands[(15 - cmdIndex) * 8 +: 8]}});
                end
                if (cmdIndex == 15) begin
                    index2B = i;
                end
                cmdIndex++;
            end
        end
        checkBit("init command count is 16", cmdIndex == 16, 1'b1);
        checkBit("init data count is 52", dataCount == 52, 1'b1);
        checkWord("2A end high byte", captured[index2B - 2], '{1'b1, 16'h0001});
        checkWord("2A end low byte", captured[index2B - 1], '{1'b1, 16'h003F});
        checkWord("2B end high byte", captured[initWords - 2], '{1'b1, 16'h0001});
        checkWord("2B end low byte", captured[initWords - 1], '{1'b1, 16'h00DF});
        while (!ready) begin
            @(negedge clock);
        end
        checkBit("no frame word before ready", captured.size() == initWords, 1'b1);
        reportTest("init words", errorsBefore);
    endtask

    task automatic testFrameStructure();
        int errorsBefore;
        errorsBefore = errorCount;
        waitWords(initWords + frameWords + 1);
        checkWord("frame 0 command", captured[initWords], memWriteCmd);
        for (int i = 1; i < frameWords; i++) begin
            checkBit($sformatf("frame 0 word %0d isData", i), captured[initWords + i].isData, 1'b1);
        end
        checkWord("frame 1 command", captured[initWords + frameWords], memWriteCmd);
        checkBit("lcdReset still single pulse", fallCount == 1, 1'b1);
        reportTest("frame structure", errorsBefore);
    endtask

    task automatic testBoxContent();
        int      errorsBefore;
        int      base;
        int      x;
        int      y;
        int      minGreen;
        int      maxGreen;
        string   name;
        rgb565_t c;
        errorsBefore = errorCount;
        waitWords(initWords + 3 * frameWords);
        for (int f = 0; f < 3; f++) begin
            base     = initWords + f * frameWords + 1;
            minGreen = boxSize;
            maxGreen = -1;
            for (int i = 0; i < frameWidth * frameHeight; i++) begin
                x    = i / frameHeight;  // column-major
                y    = i % frameHeight;
                c    = rgb565_t'(captured[base + i].value);
                name = $sformatf("frame %0d pixel x%0d y%0d", f, x, y);
                if (x < boxLeft || x >= boxLeft + boxSize || y < boxTop || y >= boxTop + boxSize) begin
                    checkColour(name, c, expBlack);
                end else if (x == boxLeft || x == boxLeft + boxSize - 1
                             || y == boxTop || y == boxTop + boxSize - 1) begin
                    checkColour(name, c, expRed);
                end else if (c === expGreen) begin
                    minGreen = (x - boxLeft < minGreen) ? x - boxLeft : minGreen;
                    maxGreen = (x - boxLeft > maxGreen) ? x - boxLeft : maxGreen;
                end else begin
                    checkColour(name, c, expBlack);
                end
            end
            checkBit($sformatf("frame %0d has green", f), maxGreen >= 0, 1'b1);
            // one phase step widens the band by a column
            checkBit($sformatf("frame %0d green band", f), maxGreen - minGreen <= 4, 1'b1);
            leftmost[f] = minGreen;
        end
        reportTest("box content", errorsBefore);
    endtask

    task automatic testAnimation();
        int errorsBefore;
        errorsBefore = errorCount;
        checkBit("green bar moved across frames",
                 leftmost[0] == leftmost[1] && leftmost[1] == leftmost[2], 1'b0);
        reportTest("animation", errorsBefore);
    endtask

    initial begin
        testResetState();
        testResetPulse();
        testInitWords();
        testFrameStructure();
        testBoxContent();
        testAnimation();
        $display("%0d tests run, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
lcdPkg.sv
lcdInitRom.sv
lcdInitSeq.sv
lcdBusWriter.sv
lcdPixelStream.sv
boxPainter.sv
lcdTop.sv
tbClockGen.sv
lcdTb.sv
